//--- common/muldiv_pkg.sv
/* Widths, encodings and types shared by the RV32M execution unit.
   Operation codes equal funct3, so the decoder casts funct3 directly.
   State literals carry a unit prefix because all enums share this scope */
`default_nettype none

package muldiv_pkg;

    // Widths --------------------
    localparam int XLEN  = 32;
    localparam int TAG_W = 5;       // Destination register number

    // Instruction fields --------------------
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // Sizing --------------------
    localparam int FIFO_DEPTH = 4;
    localparam int DIV_STEPS  = 32;
    localparam int DIV_CNT_W  = $clog2(DIV_STEPS);
    localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(DIV_STEPS - 1);

    typedef enum logic [3:0] {
        MUL        = 4'd0,
        MULH       = 4'd1,
        MULHSU     = 4'd2,
        MULHU      = 4'd3,
        DIV        = 4'd4,
        DIVU       = 4'd5,
        REM        = 4'd6,
        REMU       = 4'd7,
        OP_ILLEGAL = 4'd15  // Not an M-extension word
    } muldiv_op_e;

    // 73 bits
    typedef struct packed {
        muldiv_op_e         op;
        logic [XLEN-1:0]    src1;
        logic [XLEN-1:0]    src2;
        logic [TAG_W-1:0]   tag;
    } muldiv_cmd_t;

    // 38 bits
    typedef struct packed {
        logic [XLEN-1:0]    result;
        logic [TAG_W-1:0]   tag;
        logic               err;
    } muldiv_rsp_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_EXEC,
        MUL_RET
    } mul_state_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_CHECK,
        DIV_EXEC,
        DIV_RET
    } div_state_e;

endpackage

`default_nettype wire

//--- source/m_decoder.sv
/* Decodes one instruction word into a command and holds it in a
   single-entry output slot. Words outside OP/funct7=0000001 become OP_ILLEGAL */
`default_nettype none

module m_decoder (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            in_valid_i,
    output logic                            in_ready_o,
    input  logic [muldiv_pkg::XLEN-1:0]     in_instr_i,
    input  logic [muldiv_pkg::XLEN-1:0]     in_src1_i,
    input  logic [muldiv_pkg::XLEN-1:0]     in_src2_i,
    input  logic [muldiv_pkg::TAG_W-1:0]    in_tag_i,
    output logic                            cmd_valid_o,
    input  logic                            cmd_ready_i,
    output muldiv_pkg::muldiv_cmd_t         cmd_o
);

    logic                       up_q;       // Low in and right after reset
    logic                       slot_v_q;
    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic                       load;
    muldiv_pkg::muldiv_op_e     op;
    muldiv_pkg::muldiv_cmd_t    slot_q;

    assign opcode = in_instr_i[6:0];
    assign funct3 = in_instr_i[14:12];
    assign funct7 = in_instr_i[31:25];

    always_comb begin
        if (opcode == muldiv_pkg::OPCODE_OP && funct7 == muldiv_pkg::FUNCT7_MULDIV) begin
            op = muldiv_pkg::muldiv_op_e'({1'b0, funct3});
        end else begin
            op = muldiv_pkg::OP_ILLEGAL;
        end
    end

    // Slot accepts when empty or draining this cycle
    assign in_ready_o = up_q & (~slot_v_q | cmd_ready_i);
    assign load       = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            up_q     <= 1'b0;
            slot_v_q <= 1'b0;
        end else begin
            up_q <= 1'b1;
            if (load) begin
                slot_v_q <= 1'b1;
            end else if (cmd_ready_i) begin
                slot_v_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            slot_q <= '{op: op, src1: in_src1_i, src2: in_src2_i, tag: in_tag_i};
        end
    end

    assign cmd_valid_o = slot_v_q;
    assign cmd_o       = slot_q;

endmodule

`default_nettype wire

//--- source/cmd_fifo.sv
/* Synchronous command FIFO. DEPTH must be a power of two, 2 or more.
   Head data is valid one cycle after push; full blocks push even on pop */
`default_nettype none

module cmd_fifo #(
    parameter int DEPTH = muldiv_pkg::FIFO_DEPTH
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        push_valid_i,
    output logic                        push_ready_o,
    input  muldiv_pkg::muldiv_cmd_t     push_cmd_i,
    output logic                        pop_valid_o,
    input  logic                        pop_ready_i,
    output muldiv_pkg::muldiv_cmd_t     pop_cmd_o
);

    muldiv_pkg::muldiv_cmd_t        mem [DEPTH];
    logic [$clog2(DEPTH):0]         wr_ptr_q;   // Extra MSB is the wrap bit
    logic [$clog2(DEPTH):0]         rd_ptr_q;
    logic                           full;
    logic                           empty;
    logic                           push;
    logic                           pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[$clog2(DEPTH)] != rd_ptr_q[$clog2(DEPTH)])
                 && (wr_ptr_q[$clog2(DEPTH)-1:0] == rd_ptr_q[$clog2(DEPTH)-1:0]);

    assign push_ready_o = ~full;
    assign pop_valid_o  = ~empty;
    assign push         = push_valid_i & ~full;
    assign pop          = pop_ready_i & ~empty;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q[$clog2(DEPTH)-1:0]] <= push_cmd_i;
        end
    end

    assign pop_cmd_o = mem[rd_ptr_q[$clog2(DEPTH)-1:0]];

endmodule

`default_nettype wire

//--- muldiv/multiplier.sv
/* Two-cycle multiplier. Operands are taken only in IDLE on start_i.
   done_o is a one-cycle pulse and rslt_o is zero outside it */
`default_nettype none

module multiplier (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  muldiv_pkg::muldiv_op_e          op_i,
    input  logic [muldiv_pkg::XLEN-1:0]     src1_i,
    input  logic [muldiv_pkg::XLEN-1:0]     src2_i,
    output logic                            done_o,
    output logic [muldiv_pkg::XLEN-1:0]     rslt_o
);

    muldiv_pkg::mul_state_e                 state_q;
    logic signed [muldiv_pkg::XLEN:0]       mcand_q;    // 33-bit extended
    logic signed [muldiv_pkg::XLEN:0]       mplier_q;
    logic [2*muldiv_pkg::XLEN-1:0]          product_q;
    logic                                   is_high_q;
    logic                                   src1_signed;
    logic                                   src2_signed;

    assign src1_signed = op_i inside {muldiv_pkg::MULH, muldiv_pkg::MULHSU};
    assign src2_signed = (op_i == muldiv_pkg::MULH);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= muldiv_pkg::MUL_IDLE;
        end else begin
            case (state_q)
                muldiv_pkg::MUL_IDLE: if (start_i) state_q <= muldiv_pkg::MUL_EXEC;
                muldiv_pkg::MUL_EXEC: state_q <= muldiv_pkg::MUL_RET;
                default:              state_q <= muldiv_pkg::MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == muldiv_pkg::MUL_IDLE && start_i) begin
            mcand_q   <= {src1_signed & src1_i[muldiv_pkg::XLEN-1], src1_i};
            mplier_q  <= {src2_signed & src2_i[muldiv_pkg::XLEN-1], src2_i};
            is_high_q <= (op_i != muldiv_pkg::MUL);
        end
        if (state_q == muldiv_pkg::MUL_EXEC) begin
            product_q <= mcand_q * mplier_q;    // Signed in 64-bit context
        end
    end

    assign done_o = (state_q == muldiv_pkg::MUL_RET);
    assign rslt_o = !done_o   ? '0 :
                    is_high_q ? product_q[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN] :
                                product_q[muldiv_pkg::XLEN-1:0];

endmodule

`default_nettype wire

//--- muldiv/divider.sv
/* Radix-2 restoring divider, 34 cycles start to done, 2 on a zero divisor.
   Zero divisor gives all-ones quotient and the dividend as remainder.
   Signed overflow needs no special case since magnitudes are unsigned */
`default_nettype none

module divider (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  muldiv_pkg::muldiv_op_e          op_i,
    input  logic [muldiv_pkg::XLEN-1:0]     src1_i,
    input  logic [muldiv_pkg::XLEN-1:0]     src2_i,
    output logic                            done_o,
    output logic [muldiv_pkg::XLEN-1:0]     rslt_o
);

    localparam int W = muldiv_pkg::XLEN;

    muldiv_pkg::div_state_e                 state_q;
    logic [muldiv_pkg::DIV_CNT_W-1:0]       cntr_q;
    logic [W-1:0]                           rem_q;
    logic [W-1:0]                           quo_q;
    logic [W-1:0]                           divisor_q;
    logic                                   dividend_neg_q;
    logic                                   divisor_neg_q;
    logic                                   quo_neg_q;
    logic                                   rem_neg_q;
    logic                                   is_rem_q;
    logic                                   is_signed;
    logic [W-1:0]                           dividend_mag;
    logic [W-1:0]                           divisor_mag;
    logic [W:0]                             shifted;
    logic [W+1:0]                           diff;
    logic                                   q_bit;

    assign is_signed = op_i inside {muldiv_pkg::DIV, muldiv_pkg::REM};

    assign dividend_mag = dividend_neg_q ? (~rem_q + 1'b1) : rem_q;
    assign divisor_mag  = divisor_neg_q ? (~divisor_q + 1'b1) : divisor_q;

    // One shift-subtract step on the full 33-bit partial remainder
    assign shifted = {rem_q, quo_q[W-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_q};
    assign q_bit   = ~diff[W+1];

    // Control --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= muldiv_pkg::DIV_IDLE;
            cntr_q  <= '0;
        end else begin
            case (state_q)
                muldiv_pkg::DIV_IDLE: begin
                    if (start_i) state_q <= muldiv_pkg::DIV_CHECK;
                end
                muldiv_pkg::DIV_CHECK: begin
                    cntr_q <= muldiv_pkg::DIV_LAST;
                    if (divisor_q == '0) begin
                        state_q <= muldiv_pkg::DIV_RET;
                    end else begin
                        state_q <= muldiv_pkg::DIV_EXEC;
                    end
                end
                muldiv_pkg::DIV_EXEC: begin
                    cntr_q <= cntr_q - 1'b1;
                    if (cntr_q == '0) state_q <= muldiv_pkg::DIV_RET;
                end
                default: state_q <= muldiv_pkg::DIV_IDLE;
            endcase
        end
    end

    // Datapath --------------------
    always_ff @(posedge clk_i) begin
        case (state_q)
            muldiv_pkg::DIV_IDLE: begin
                if (start_i) begin
                    is_rem_q       <= op_i inside {muldiv_pkg::REM, muldiv_pkg::REMU};
                    dividend_neg_q <= is_signed & src1_i[W-1];
                    divisor_neg_q  <= is_signed & src2_i[W-1];
                    quo_neg_q      <= is_signed & (src1_i[W-1] ^ src2_i[W-1]);
                    rem_neg_q      <= is_signed & src1_i[W-1];
                    divisor_q      <= src2_i;
                    rem_q          <= src1_i;   // Dividend parked here
                    quo_q          <= '0;
                end
            end
            muldiv_pkg::DIV_CHECK: begin
                if (divisor_q == '0) begin
                    quo_neg_q <= 1'b0;
                    rem_neg_q <= 1'b0;
                    quo_q     <= '1;            // rem_q keeps the dividend
                end else begin
                    divisor_q <= divisor_mag;
                    rem_q     <= '0;
                    quo_q     <= dividend_mag;
                end
            end
            muldiv_pkg::DIV_EXEC: begin
                rem_q <= q_bit ? diff[W-1:0] : shifted[W-1:0];
                quo_q <= {quo_q[W-2:0], q_bit};
            end
            default: begin
            end
        endcase
    end

    assign done_o = (state_q == muldiv_pkg::DIV_RET);
    assign rslt_o = !done_o   ? '0 :
                    is_rem_q  ? (rem_neg_q ? (~rem_q + 1'b1) : rem_q) :
                                (quo_neg_q ? (~quo_q + 1'b1) : quo_q);

endmodule

`default_nettype wire

//--- muldiv/muldiv_engine.sv
/* Runs one command at a time on the multiplier or divider.
   No pop while a unit is busy or a response waits, so order is kept */
`default_nettype none

module muldiv_engine (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        cmd_valid_i,
    output logic                        cmd_ready_o,
    input  muldiv_pkg::muldiv_cmd_t     cmd_i,
    output logic                        rsp_valid_o,
    input  logic                        rsp_ready_i,
    output muldiv_pkg::muldiv_rsp_t     rsp_o
);

    logic                               busy_q;
    logic                               rsp_valid_q;
    muldiv_pkg::muldiv_rsp_t            rsp_q;
    logic                               pop;
    logic                               is_mul;
    logic                               is_div;
    logic                               mul_done;
    logic                               div_done;
    logic [muldiv_pkg::XLEN-1:0]        mul_rslt;
    logic [muldiv_pkg::XLEN-1:0]        div_rslt;

    assign is_mul = cmd_i.op inside {muldiv_pkg::MUL, muldiv_pkg::MULH,
                                     muldiv_pkg::MULHSU, muldiv_pkg::MULHU};
    assign is_div = cmd_i.op inside {muldiv_pkg::DIV, muldiv_pkg::DIVU,
                                     muldiv_pkg::REM, muldiv_pkg::REMU};

    assign cmd_ready_o = ~busy_q & ~rsp_valid_q;
    assign pop         = cmd_valid_i & cmd_ready_o;

    multiplier u_mul (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (pop & is_mul),
        .op_i    (cmd_i.op),
        .src1_i  (cmd_i.src1),
        .src2_i  (cmd_i.src2),
        .done_o  (mul_done),
        .rslt_o  (mul_rslt)
    );

    divider u_div (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (pop & is_div),
        .op_i    (cmd_i.op),
        .src1_i  (cmd_i.src1),
        .src2_i  (cmd_i.src2),
        .done_o  (div_done),
        .rslt_o  (div_rslt)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (pop) begin
                if (is_mul | is_div) begin
                    busy_q <= 1'b1;
                end else begin
                    rsp_valid_q <= 1'b1;    // Illegal word answers at once
                end
            end
            if (busy_q & (mul_done | div_done)) begin
                busy_q      <= 1'b0;
                rsp_valid_q <= 1'b1;
            end
            if (rsp_valid_q & rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge clk_i) begin
        if (pop) begin
            rsp_q.tag    <= cmd_i.tag;
            rsp_q.err    <= ~(is_mul | is_div);
            rsp_q.result <= '0;
        end else if (busy_q & (mul_done | div_done)) begin
            rsp_q.result <= mul_done ? mul_rslt : div_rslt;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

//--- source/muldiv_top.sv
/* RV32M execution unit. Responses return in input order with variable latency.
   Up to FIFO_DEPTH plus 2 commands may be in flight */
`default_nettype none

module muldiv_top (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            in_valid_i,
    output logic                            in_ready_o,
    input  logic [muldiv_pkg::XLEN-1:0]     in_instr_i,
    input  logic [muldiv_pkg::XLEN-1:0]     in_src1_i,
    input  logic [muldiv_pkg::XLEN-1:0]     in_src2_i,
    input  logic [muldiv_pkg::TAG_W-1:0]    in_tag_i,
    output logic                            rsp_valid_o,
    input  logic                            rsp_ready_i,
    output muldiv_pkg::muldiv_rsp_t         rsp_o
);

    logic                       dec_valid;
    logic                       dec_ready;
    muldiv_pkg::muldiv_cmd_t    dec_cmd;
    logic                       fifo_valid;
    logic                       fifo_ready;
    muldiv_pkg::muldiv_cmd_t    fifo_cmd;

    m_decoder u_dec (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_instr_i  (in_instr_i),
        .in_src1_i   (in_src1_i),
        .in_src2_i   (in_src2_i),
        .in_tag_i    (in_tag_i),
        .cmd_valid_o (dec_valid),
        .cmd_ready_i (dec_ready),
        .cmd_o       (dec_cmd)
    );

    cmd_fifo #(
        .DEPTH (muldiv_pkg::FIFO_DEPTH)
    ) u_fifo (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .push_valid_i (dec_valid),
        .push_ready_o (dec_ready),
        .push_cmd_i   (dec_cmd),
        .pop_valid_o  (fifo_valid),
        .pop_ready_i  (fifo_ready),
        .pop_cmd_o    (fifo_cmd)
    );

    muldiv_engine u_eng (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (fifo_valid),
        .cmd_ready_o (fifo_ready),
        .cmd_i       (fifo_cmd),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

endmodule

`default_nettype wire

//--- tb/muldiv_asserts.sv
/* Handshake and response rules of muldiv_top, bound into the DUT.
   fail_count is read by the testbench at the end of the run */
`default_nettype none

module muldiv_asserts (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        in_ready_o,
    input  logic                        rsp_valid_o,
    input  logic                        rsp_ready_i,
    input  muldiv_pkg::muldiv_rsp_t     rsp_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Response held until taken
    rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
        else begin
            fail_count++;
            $error("rsp_o changed or rsp_valid_o dropped before rsp_ready_i");
        end

    in_ready_reset: assert property (@(posedge clk_i) rst_i |=> !in_ready_o)
        else begin
            fail_count++;
            $error("in_ready_o high right after reset");
        end

    err_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_o && rsp_o.err |-> rsp_o.result == '0)
        else begin
            fail_count++;
            $error("error response with a nonzero result");
        end

endmodule

`default_nettype wire

//--- tb/muldiv_tb.sv
/* Directed tests for the RV32M execution unit, checked in order against a model.
   Responses are matched at the falling edge against one expected entry per accepted input */
`default_nettype none

module muldiv_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT = 1000;    // Cycles per wait loop
    localparam logic [31:0] SEED    = 32'hc32a2403;

    logic                           clk_i;
    logic                           rst_i;
    logic                           in_valid_i;
    logic                           in_ready_o;
    logic [31:0]                    in_instr_i;
    logic [31:0]                    in_src1_i;
    logic [31:0]                    in_src2_i;
    logic [4:0]                     in_tag_i;
    logic                           rsp_valid_o;
    logic                           rsp_ready_i;
    muldiv_pkg::muldiv_rsp_t        rsp_o;

    muldiv_pkg::muldiv_rsp_t        exp_q [$];  // Expected responses, input order
    int                             check_count;
    int                             mismatch_count;
    int                             other_errors;
    logic [31:0]                    stim_rng;
    logic [31:0]                    ready_rng;

    muldiv_top dut (.*);

    bind muldiv_top muldiv_asserts u_asserts (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_ready_o  (in_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    always #10 clk_i = ~clk_i;

    // Model --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] encode_instr(input logic [6:0] f7, input logic [2:0] f3,
                                                 input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};    // rs2=x2 rs1=x1 rd=x3
    endfunction

    function automatic logic [31:0] model_result(input logic [2:0] f3,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [63:0]        p;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               ovf;
        sa  = a;
        sb  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f3)
            3'd0:    p = {32'b0, a} * {32'b0, b};
            3'd1:    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // Wraps mod 2^64
            3'd2:    p = {{32{a[31]}}, a} * {32'b0, b};
            3'd3:    p = {32'b0, a} * {32'b0, b};
            3'd4:    p = (b == 0) ? 64'hffff_ffff : ovf ? {32'b0, a} : {32'b0, sa / sb};
            3'd5:    p = (b == 0) ? 64'hffff_ffff : {32'b0, a / b};
            3'd6:    p = (b == 0) ? {32'b0, a} : ovf ? 64'd0 : {32'b0, sa % sb};
            default: p = (b == 0) ? {32'b0, a} : {32'b0, a % b};
        endcase
        return (f3 inside {3'd1, 3'd2, 3'd3}) ? p[63:32] : p[31:0];
    endfunction

    // Checking --------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Response monitor sampling handshakes that complete at the next rising edge
    always @(negedge clk_i) begin
        muldiv_pkg::muldiv_rsp_t exp;
        if (!rst_i && rsp_valid_o && rsp_ready_i) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("ERROR at %0t: response with tag %0d arrived but none was expected",
                         $time, rsp_o.tag);
            end else begin
                exp = exp_q.pop_front();
                check_value("rsp_o.result", rsp_o.result, exp.result);
                check_value("rsp_o.tag", 32'(rsp_o.tag), 32'(exp.tag));
                check_value("rsp_o.err", 32'(rsp_o.err), 32'(exp.err));
            end
        end
    end

    // Stimulus --------------------
    task automatic try_send(input logic [31:0] instr, input logic [31:0] a,
                            input logic [31:0] b, input logic [4:0] tag,
                            input int max_wait, output bit accepted);
        muldiv_pkg::muldiv_rsp_t exp;
        logic                    legal;
        legal = (instr[6:0] == muldiv_pkg::OPCODE_OP)
              && (instr[31:25] == muldiv_pkg::FUNCT7_MULDIV);
        exp.result = legal ? model_result(instr[14:12], a, b) : 32'd0;
        exp.tag    = tag;
        exp.err    = ~legal;
        @(posedge clk_i);
        in_valid_i <= 1'b1;
        in_instr_i <= instr;
        in_src1_i  <= a;
        in_src2_i  <= b;
        in_tag_i   <= tag;
        accepted = 1'b0;
        for (int w = 0; w < max_wait && !accepted; w++) begin
            @(negedge clk_i);
            if (in_ready_o) accepted = 1'b1;
        end
        if (accepted) exp_q.push_back(exp);
        @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    task automatic send_cmd(input logic [31:0] instr, input logic [31:0] a,
                            input logic [31:0] b, input logic [4:0] tag);
        bit ok;
        try_send(instr, a, b, tag, TIMEOUT, ok);
        if (!ok) begin
            other_errors++;
            $display("ERROR at %0t: input with tag %0d was never accepted", $time, tag);
        end
    endtask

    task automatic drain_responses(input int max_cycles);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < max_cycles) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("ERROR at %0t: %0d responses still missing after %0d cycles",
                     $time, exp_q.size(), max_cycles);
            exp_q.delete();
        end
    endtask

    // Tests --------------------
    task automatic reset_test();
        int waited;
        rst_i <= 1'b1;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
        waited = 0;
        while (!in_ready_o && waited < 10) begin
            @(negedge clk_i);
            waited++;
        end
        if (!in_ready_o) begin
            other_errors++;
            $display("ERROR at %0t: in_ready_o did not rise after reset", $time);
        end
    endtask

    task automatic multiply_test();
        logic [31:0] a_vals [3] = '{32'h7fff_fff3, 32'h8000_0000, 32'hdead_beef};
        logic [31:0] b_vals [3] = '{32'hffff_fe0c, 32'h8000_0000, 32'h0000_1234};
        @(posedge clk_i);
        rsp_ready_i <= 1'b1;
        for (int f = 0; f < 4; f++) begin
            for (int k = 0; k < 3; k++) begin
                send_cmd(encode_instr(muldiv_pkg::FUNCT7_MULDIV, 3'(f), muldiv_pkg::OPCODE_OP),
                         a_vals[k], b_vals[k], 5'(f * 3 + k));
            end
        end
        drain_responses(TIMEOUT);
    endtask

    task automatic divide_test();
        logic [31:0] a_vals [5] = '{32'd100, -32'd100, 32'd100, 32'h1234_5678, 32'h8000_0000};
        logic [31:0] b_vals [5] = '{32'd7, 32'd7, -32'd7, 32'd0, 32'hffff_ffff};
        @(posedge clk_i);
        rsp_ready_i <= 1'b1;
        for (int f = 4; f < 8; f++) begin
            for (int k = 0; k < 5; k++) begin
                send_cmd(encode_instr(muldiv_pkg::FUNCT7_MULDIV, 3'(f), muldiv_pkg::OPCODE_OP),
                         a_vals[k], b_vals[k], 5'(f * 5 + k));
            end
        end
        drain_responses(TIMEOUT);
    endtask

    task automatic illegal_test();
        @(posedge clk_i);
        rsp_ready_i <= 1'b1;
        send_cmd(encode_instr(7'b0000000, 3'd0, muldiv_pkg::OPCODE_OP), 32'd5, 32'd6, 5'd21);
        send_cmd(encode_instr(7'b0100000, 3'd4, muldiv_pkg::OPCODE_OP), 32'd9, 32'd3, 5'd22);
        send_cmd(encode_instr(muldiv_pkg::FUNCT7_MULDIV, 3'd1, 7'b0010011), 32'd7, 32'd8, 5'd23);
        drain_responses(TIMEOUT);
    endtask

    task automatic backpressure_test();
        int accepted;
        bit ok;
        @(posedge clk_i);
        rsp_ready_i <= 1'b0;
        accepted = 0;
        ok       = 1'b1;
        for (int i = 0; i < 2 * muldiv_pkg::FIFO_DEPTH + 4 && ok; i++) begin
            try_send(encode_instr(muldiv_pkg::FUNCT7_MULDIV, 3'(i), muldiv_pkg::OPCODE_OP),
                     32'h1234_5678 * (i + 1), 32'hffff_fff0 + i, 5'(i), 50, ok);
            if (ok) accepted++;
        end
        if (ok) begin
            other_errors++;
            $display("ERROR at %0t: in_ready_o never stayed low under back-pressure", $time);
        end
        if (accepted == 0 || accepted > muldiv_pkg::FIFO_DEPTH + 2) begin
            other_errors++;
            $display("ERROR at %0t: %0d commands accepted under back-pressure", $time, accepted);
        end
        @(posedge clk_i);
        rsp_ready_i <= 1'b1;
        drain_responses(TIMEOUT);
    endtask

    task automatic random_test();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [6:0]  f7;
        bit          done;
        done = 1'b0;
        fork
            begin
                for (int i = 0; i < 200; i++) begin
                    stim_rng = lcg_next(stim_rng);
                    r        = stim_rng;
                    stim_rng = lcg_next(stim_rng);
                    a        = stim_rng;
                    stim_rng = lcg_next(stim_rng);
                    b        = stim_rng;
                    if (r[19:16] == 4'd0) b = 32'd0;
                    if (r[19:16] == 4'd1) begin
                        a = 32'h8000_0000;
                        b = 32'hffff_ffff;
                    end
                    f7 = (r[23:20] == 4'd0) ? 7'b0100000 : muldiv_pkg::FUNCT7_MULDIV;
                    send_cmd(encode_instr(f7, r[26:24], muldiv_pkg::OPCODE_OP), a, b, r[31:27]);
                end
                drain_responses(TIMEOUT);
                done = 1'b1;
            end
            begin
                while (!done) begin
                    @(posedge clk_i);
                    ready_rng   = lcg_next(ready_rng);
                    rsp_ready_i <= ready_rng[30];
                end
            end
        join
        rsp_ready_i <= 1'b1;
    endtask

    initial begin
        int asserts_failed;
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        in_valid_i     = 1'b0;
        in_instr_i     = '0;
        in_src1_i      = '0;
        in_src2_i      = '0;
        in_tag_i       = '0;
        rsp_ready_i    = 1'b1;
        check_count    = 0;
        mismatch_count = 0;
        other_errors   = 0;
        stim_rng       = SEED;
        ready_rng      = ~SEED;    // Separate stream for rsp_ready_i
        reset_test();
        multiply_test();
        divide_test();
        illegal_test();
        backpressure_test();
        random_test();
        repeat (2) @(posedge clk_i);
        asserts_failed = dut.u_asserts.fail_count;
        $display("Checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 check_count, mismatch_count, other_errors, asserts_failed);
        if (mismatch_count == 0 && other_errors == 0 && asserts_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
common/muldiv_pkg.sv
source/m_decoder.sv
source/cmd_fifo.sv
muldiv/multiplier.sv
muldiv/divider.sv
muldiv/muldiv_engine.sv
source/muldiv_top.sv
tb/muldiv_asserts.sv
tb/muldiv_tb.sv

//--- Bender.yml
package:
  name: muldiv

sources:
  - common/muldiv_pkg.sv
  - source/m_decoder.sv
  - source/cmd_fifo.sv
  - muldiv/multiplier.sv
  - muldiv/divider.sv
  - muldiv/muldiv_engine.sv
  - source/muldiv_top.sv
  - target: test
    files:
      - tb/muldiv_asserts.sv
      - tb/muldiv_tb.sv
